/* vbuf_geom_pkg.sv */
// Vector store buffer geometry
// Lane count, RAM sizing and the vector types for addresses, words and counts

package vbuf_geom_pkg;

  //////////////////////////////////////////////////////////////////////
  // Lane and register geometry
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned LANE_NUM   = 4;   // Vector lanes feeding the buffer
  localparam int unsigned LANE_IDX_W = 2;   // log2(LANE_NUM)
  localparam int unsigned VLENB      = 64;  // Vector register length in bytes

  //////////////////////////////////////////////////////////////////////
  // Storage sizing
  //////////////////////////////////////////////////////////////////////

  // LMUL 8 gives 512 bytes, i.e. 128 bytes or 32 words per lane
  localparam int unsigned BUFF_DEPTH = 32;
  localparam int unsigned WADDR_W    = 5;   // log2(BUFF_DEPTH)

  // Up to 512 elements at SEW 8 and LMUL 8
  localparam int unsigned CNT_W      = 10;

  //////////////////////////////////////////////////////////////////////
  // Vector types
  //////////////////////////////////////////////////////////////////////

  typedef logic [31:0]      addr_t;  // Byte address
  typedef logic [31:0]      word_t;  // RAM and bus word
  typedef logic [CNT_W-1:0] cnt_t;   // Element or beat count
  typedef logic [3:0]       be_t;    // Byte enables of one word

endpackage

/* vbuf_fmt_pkg.sv */
// Vector store buffer element format
// SEW encoding, lane element type and per-SEW size tables

package vbuf_fmt_pkg;

  // Element width, encoded as log2 of the element byte size
  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } sew_e;

  // Lane element, only the low SEW bits are meaningful
  typedef logic [31:0] elem_t;

  //////////////////////////////////////////////////////////////////////
  // Element-size tables, indexed by sew_e
  //////////////////////////////////////////////////////////////////////

  // Byte mask of one element at byte offset 0
  localparam vbuf_geom_pkg::be_t ELEM_MASK [3] = '{4'b0001, 4'b0011, 4'b1111};

  // log2 of the elements held in one 32-bit word
  localparam logic [1:0] WORD_SHIFT [3] = '{2'd2, 2'd1, 2'd0};

  // Element size in bytes, the unit-stride address step
  localparam logic [2:0] ELEM_BYTES [3] = '{3'd1, 3'd2, 3'd4};

endpackage

/* vbuf_config.sv */
// Transfer configuration registers
// Holds SEW and stride settings and turns LMUL into an element count

`timescale 1ns/100ps

module vbuf_config (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  cfg_update_i,
  input  vbuf_fmt_pkg::sew_e    cfg_sew_i,
  input  logic [1:0]            cfg_l2_lmul_i,
  input  logic                  cfg_lmul_grow_i,
  input  logic                  cfg_strided_i,
  input  vbuf_geom_pkg::addr_t  cfg_stride_i,
  output vbuf_fmt_pkg::sew_e    sew_o,
  output logic                  strided_o,
  output vbuf_geom_pkg::addr_t  stride_o,
  output vbuf_geom_pkg::cnt_t   elem_cnt_o
);

  vbuf_geom_pkg::cnt_t byte_cnt;  // Bytes in the register group

  //////////////////////////////////////////////////////////////////////
  // Element count
  //////////////////////////////////////////////////////////////////////

  // Register group size, VLENB scaled up or down by LMUL
  always_comb begin
    if (cfg_lmul_grow_i) begin
      byte_cnt = vbuf_geom_pkg::cnt_t'(vbuf_geom_pkg::VLENB) << cfg_l2_lmul_i;
    end else begin
      byte_cnt = vbuf_geom_pkg::cnt_t'(vbuf_geom_pkg::VLENB) >> cfg_l2_lmul_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Configuration registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      sew_o      <= vbuf_fmt_pkg::SEW8;
      strided_o  <= 1'b0;
      stride_o   <= '0;
      elem_cnt_o <= '0;
    end else if (cfg_update_i) begin
      sew_o      <= cfg_sew_i;
      strided_o  <= cfg_strided_i;
      stride_o   <= cfg_stride_i;
      elem_cnt_o <= byte_cnt >> cfg_sew_i;  // Divide by element byte size
    end
  end

endmodule

/* vbuf_lane_pack.sv */
// Write side of the store buffer
// Counts write beats and packs narrow lane elements into the lane RAM words

`timescale 1ns/100ps

module vbuf_lane_pack (
  input  logic                                     clk,
  input  logic                                     rstn,
  input  logic                                     cfg_update_i,
  input  logic                                     wen_i,
  input  vbuf_fmt_pkg::sew_e                       sew_i,
  input  vbuf_geom_pkg::cnt_t                      elem_cnt_i,
  input  vbuf_fmt_pkg::elem_t                      lane_data_i [vbuf_geom_pkg::LANE_NUM],
  output vbuf_geom_pkg::be_t                       ram_we_o    [vbuf_geom_pkg::LANE_NUM],
  output logic [vbuf_geom_pkg::WADDR_W-1:0]        ram_waddr_o,
  output vbuf_geom_pkg::word_t                     ram_wdata_o [vbuf_geom_pkg::LANE_NUM],
  output logic                                     write_done_o,
  output logic                                     not_empty_o
);

  vbuf_geom_pkg::cnt_t wr_beat;       // Beats taken so far
  vbuf_geom_pkg::cnt_t beat_total;    // Beats in the whole transfer
  vbuf_geom_pkg::cnt_t wr_word;       // Word index of the current beat
  logic                wr_take;
  logic [3:0]          wr_slot_full;  // Byte offset before wrap
  vbuf_geom_pkg::be_t  wr_be;

  assign beat_total = elem_cnt_i >> vbuf_geom_pkg::LANE_IDX_W;  // One element per lane per beat
  assign wr_take    = wen_i && !write_done_o;                   // Late strobes are dropped

  //////////////////////////////////////////////////////////////////////
  // Beat counter and status
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn || cfg_update_i) begin
      wr_beat      <= '0;
      write_done_o <= 1'b0;
      not_empty_o  <= 1'b0;
    end else if (wr_take) begin
      wr_beat     <= wr_beat + 1'b1;
      not_empty_o <= 1'b1;
      if (wr_beat == beat_total - 1'b1)
        write_done_o <= 1'b1;  // Last beat of the transfer
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Word address and byte enable rotation
  //////////////////////////////////////////////////////////////////////

  // 4, 2 or 1 beats share a word depending on SEW
  assign wr_word      = wr_beat >> vbuf_fmt_pkg::WORD_SHIFT[sew_i];
  assign ram_waddr_o  = wr_word[vbuf_geom_pkg::WADDR_W-1:0];
  assign wr_slot_full = {2'b00, wr_beat[1:0]} << sew_i;
  assign wr_be        = vbuf_fmt_pkg::ELEM_MASK[sew_i] << wr_slot_full[1:0];

  // Narrow data goes to every slot, the enables pick the live one
  always_comb begin
    for (int l = 0; l < vbuf_geom_pkg::LANE_NUM; l++) begin
      ram_we_o[l] = wr_take ? wr_be : '0;
      case (sew_i)
        vbuf_fmt_pkg::SEW8:  ram_wdata_o[l] = {4{lane_data_i[l][7:0]}};
        vbuf_fmt_pkg::SEW16: ram_wdata_o[l] = {2{lane_data_i[l][15:0]}};
        default:             ram_wdata_o[l] = lane_data_i[l];
      endcase
    end
  end

endmodule

/* vbuf_lane_ram.sv */
// Lane RAM
// Simple dual-port single-clock storage with byte write and registered read

`timescale 1ns/100ps

module vbuf_lane_ram #(
  parameter int unsigned DEPTH = 32
) (
  input  logic                       clk,
  input  vbuf_geom_pkg::be_t         we_i,
  input  logic [$clog2(DEPTH)-1:0]   waddr_i,
  input  vbuf_geom_pkg::word_t       wdata_i,
  input  logic                       re_i,
  input  logic [$clog2(DEPTH)-1:0]   raddr_i,
  output vbuf_geom_pkg::word_t       rdata_o
);

  vbuf_geom_pkg::word_t mem [DEPTH];

  //////////////////////////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    for (int b = 0; b < 4; b++) begin
      if (we_i[b])
        mem[waddr_i][8*b +: 8] <= wdata_i[8*b +: 8];  // One byte column
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Read port
  //////////////////////////////////////////////////////////////////////

  // Read data register, holds its value when not enabled
  always_ff @(posedge clk) begin
    if (re_i)
      rdata_o <= mem[raddr_i];
  end

endmodule

/* vbuf_addr_gen.sv */
// Element address generator
// Keeps the running byte address for unit-stride and strided transfers

`timescale 1ns/100ps

module vbuf_addr_gen (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  cfg_update_i,
  input  vbuf_geom_pkg::addr_t  base_i,
  input  logic                  step_i,
  input  logic                  strided_i,
  input  vbuf_geom_pkg::addr_t  stride_i,
  input  vbuf_fmt_pkg::sew_e    sew_i,
  output vbuf_geom_pkg::addr_t  addr_o
);

  vbuf_geom_pkg::addr_t addr_step;  // Distance to the next element
  vbuf_geom_pkg::addr_t addr_q;

  //////////////////////////////////////////////////////////////////////
  // Step size
  //////////////////////////////////////////////////////////////////////

  // Unit stride moves by one element, strided by the programmed stride
  always_comb begin
    if (strided_i) begin
      addr_step = stride_i;
    end else begin
      addr_step = vbuf_geom_pkg::addr_t'(vbuf_fmt_pkg::ELEM_BYTES[sew_i]);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Running address
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      addr_q <= '0;
    end else if (cfg_update_i) begin
      addr_q <= base_i;              // New transfer starts at the base
    end else if (step_i) begin
      addr_q <= addr_q + addr_step;
    end
  end

  assign addr_o = addr_q;  // Address of the element read next

endmodule

/* vbuf_drain.sv */
// Read side of the store buffer
// Drains elements in index order and forms the aligned bus address, data and strobe

`timescale 1ns/100ps

module vbuf_drain (
  input  logic                                clk,
  input  logic                                rstn,
  input  logic                                cfg_update_i,
  input  logic                                ren_i,
  input  vbuf_fmt_pkg::sew_e                  sew_i,
  input  vbuf_geom_pkg::cnt_t                 elem_cnt_i,
  input  vbuf_geom_pkg::addr_t                addr_i,
  input  vbuf_geom_pkg::word_t                ram_rdata_i [vbuf_geom_pkg::LANE_NUM],
  output logic                                ram_re_o,
  output logic [vbuf_geom_pkg::WADDR_W-1:0]   ram_raddr_o,
  output logic                                step_o,
  output logic                                read_done_o,
  output logic                                out_valid_o,
  output vbuf_geom_pkg::addr_t                out_addr_o,
  output vbuf_geom_pkg::word_t                out_data_o,
  output vbuf_geom_pkg::be_t                  out_strb_o
);

  vbuf_geom_pkg::cnt_t                    rd_idx;        // Next element index
  vbuf_geom_pkg::cnt_t                    rd_beat;       // Write beat holding that element
  vbuf_geom_pkg::cnt_t                    rd_word;
  logic                                   rd_take;
  logic [3:0]                             rd_slot_full;
  logic                                   s1_valid;      // RAM read stage
  logic [vbuf_geom_pkg::LANE_IDX_W-1:0]   s1_lane;
  logic [1:0]                             s1_slot;
  vbuf_geom_pkg::addr_t                   s1_addr;
  vbuf_geom_pkg::word_t                   s1_elem;
  vbuf_geom_pkg::word_t                   bit_mask;

  //////////////////////////////////////////////////////////////////////
  // Element counter and RAM read
  //////////////////////////////////////////////////////////////////////

  assign rd_take      = ren_i && !read_done_o;
  assign rd_beat      = rd_idx >> vbuf_geom_pkg::LANE_IDX_W;
  assign rd_word      = rd_beat >> vbuf_fmt_pkg::WORD_SHIFT[sew_i];
  assign rd_slot_full = {2'b00, rd_beat[1:0]} << sew_i;  // Byte offset inside the RAM word
  assign ram_re_o     = rd_take;
  assign ram_raddr_o  = rd_word[vbuf_geom_pkg::WADDR_W-1:0];
  assign step_o       = rd_take;   // Address moves on with each element

  always_ff @(posedge clk) begin
    if (!rstn || cfg_update_i) begin
      rd_idx      <= '0;
      read_done_o <= 1'b0;
    end else if (rd_take) begin
      rd_idx <= rd_idx + 1'b1;
      if (rd_idx == elem_cnt_i - 1'b1)
        read_done_o <= 1'b1;
    end
  end

  // Lane, slot and address follow the read by one cycle
  always_ff @(posedge clk) begin
    if (!rstn || cfg_update_i) s1_valid <= 1'b0;
    else                       s1_valid <= rd_take;
  end

  always_ff @(posedge clk) begin
    if (rd_take) begin
      s1_lane <= rd_idx[vbuf_geom_pkg::LANE_IDX_W-1:0];  // Element i sits in lane i mod LANE_NUM
      s1_slot <= rd_slot_full[1:0];
      s1_addr <= addr_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Element extract and output register
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int b = 0; b < 4; b++)
      bit_mask[8*b +: 8] = {8{vbuf_fmt_pkg::ELEM_MASK[sew_i][b]}};
    // Move the slot down to bit 0 and clear the other slots
    s1_elem = (ram_rdata_i[s1_lane] >> {s1_slot, 3'b000}) & bit_mask;
  end

  always_ff @(posedge clk) begin
    if (!rstn || cfg_update_i) out_valid_o <= 1'b0;
    else                       out_valid_o <= s1_valid;
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      out_addr_o <= {s1_addr[31:2], 2'b00};                    // Word aligned
      out_data_o <= s1_elem << {s1_addr[1:0], 3'b000};          // To the address byte lane
      out_strb_o <= vbuf_fmt_pkg::ELEM_MASK[sew_i] << s1_addr[1:0];
    end
  end

endmodule

/* vbuf_top.sv */
// Vector store buffer top level
// Lane elements in, one aligned bus write per element out

`timescale 1ns/100ps

module vbuf_top (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  cfg_update_i,
  input  vbuf_fmt_pkg::sew_e    cfg_sew_i,
  input  logic [1:0]            cfg_l2_lmul_i,
  input  logic                  cfg_lmul_grow_i,
  input  logic                  cfg_strided_i,
  input  vbuf_geom_pkg::addr_t  cfg_stride_i,
  input  vbuf_geom_pkg::addr_t  cfg_base_i,
  input  logic                  wen_i,
  input  vbuf_fmt_pkg::elem_t   lane_data_i [vbuf_geom_pkg::LANE_NUM],
  input  logic                  ren_i,
  output logic                  write_done_o,
  output logic                  read_done_o,
  output logic                  not_empty_o,
  output logic                  out_valid_o,
  output vbuf_geom_pkg::addr_t  out_addr_o,
  output vbuf_geom_pkg::word_t  out_data_o,
  output vbuf_geom_pkg::be_t    out_strb_o
);

  vbuf_fmt_pkg::sew_e                  cfg_sew;
  logic                                cfg_strided;
  vbuf_geom_pkg::addr_t                cfg_stride;
  vbuf_geom_pkg::cnt_t                 elem_cnt;
  vbuf_geom_pkg::be_t                  ram_we    [vbuf_geom_pkg::LANE_NUM];
  logic [vbuf_geom_pkg::WADDR_W-1:0]   ram_waddr;
  vbuf_geom_pkg::word_t                ram_wdata [vbuf_geom_pkg::LANE_NUM];
  logic                                ram_re;
  logic [vbuf_geom_pkg::WADDR_W-1:0]   ram_raddr;
  vbuf_geom_pkg::word_t                ram_rdata [vbuf_geom_pkg::LANE_NUM];
  logic                                step;
  vbuf_geom_pkg::addr_t                elem_addr;

  vbuf_config u_config (
    .clk, .rstn, .cfg_update_i, .cfg_sew_i, .cfg_l2_lmul_i, .cfg_lmul_grow_i,
    .cfg_strided_i, .cfg_stride_i,
    .sew_o(cfg_sew), .strided_o(cfg_strided), .stride_o(cfg_stride), .elem_cnt_o(elem_cnt)
  );

  vbuf_lane_pack u_lane_pack (
    .clk, .rstn, .cfg_update_i, .wen_i, .sew_i(cfg_sew), .elem_cnt_i(elem_cnt), .lane_data_i,
    .ram_we_o(ram_we), .ram_waddr_o(ram_waddr), .ram_wdata_o(ram_wdata),
    .write_done_o, .not_empty_o
  );

  // One byte-write RAM per lane, shared addresses
  for (genvar l = 0; l < vbuf_geom_pkg::LANE_NUM; l++) begin : g_lane
    vbuf_lane_ram #(.DEPTH(vbuf_geom_pkg::BUFF_DEPTH)) u_ram (
      .clk, .we_i(ram_we[l]), .waddr_i(ram_waddr), .wdata_i(ram_wdata[l]),
      .re_i(ram_re), .raddr_i(ram_raddr), .rdata_o(ram_rdata[l])
    );
  end

  vbuf_addr_gen u_addr_gen (
    .clk, .rstn, .cfg_update_i, .base_i(cfg_base_i), .step_i(step),
    .strided_i(cfg_strided), .stride_i(cfg_stride), .sew_i(cfg_sew), .addr_o(elem_addr)
  );

  vbuf_drain u_drain (
    .clk, .rstn, .cfg_update_i, .ren_i, .sew_i(cfg_sew), .elem_cnt_i(elem_cnt),
    .addr_i(elem_addr), .ram_rdata_i(ram_rdata),
    .ram_re_o(ram_re), .ram_raddr_o(ram_raddr), .step_o(step),
    .read_done_o, .out_valid_o, .out_addr_o, .out_data_o, .out_strb_o
  );

endmodule

/* vbuf_checker.sv */
// Timing assertions for the vector store buffer
// Bound into the top level, relates output pulses and done flags to the strobes

`timescale 1ns/100ps

module vbuf_checker (
  input logic               clk,
  input logic               rstn,
  input logic               ren_i,
  input logic               write_done_i,
  input logic               read_done_i,
  input logic               out_valid_i,
  input vbuf_geom_pkg::be_t out_strb_i
);

  int fail_cnt = 0;  // Failed assertions so far

  // Every output pulse has its read strobe two cycles back
  a_valid_latency: assert property (@(posedge clk) disable iff (!rstn)
    out_valid_i |-> $past(ren_i, 2))
    else begin
      fail_cnt++;
      $error("out_valid_o without a read strobe two cycles earlier");
    end

  a_strb_nonzero: assert property (@(posedge clk) disable iff (!rstn)
    out_valid_i |-> out_strb_i != '0)
    else begin
      fail_cnt++;
      $error("out_strb_o is zero during an output pulse");
    end

  // Reading cannot finish before the buffer was filled
  a_done_order: assert property (@(posedge clk) disable iff (!rstn)
    $rose(read_done_i) |-> write_done_i)
    else begin
      fail_cnt++;
      $error("read_done_o rose while write_done_o was low");
    end

endmodule

/* vbuf_monitor.sv */
// Output checker for the vector store buffer
// Mirrors the written elements and compares each drained element with a reference model

`timescale 1ns/100ps

module vbuf_monitor (
  input  logic                  clk,
  input  logic                  rstn,
  input  logic                  cfg_update_i,
  input  vbuf_fmt_pkg::sew_e    cfg_sew_i,
  input  logic [1:0]            cfg_l2_lmul_i,
  input  logic                  cfg_lmul_grow_i,
  input  logic                  cfg_strided_i,
  input  vbuf_geom_pkg::addr_t  cfg_stride_i,
  input  vbuf_geom_pkg::addr_t  cfg_base_i,
  input  logic                  wen_i,
  input  vbuf_fmt_pkg::elem_t   lane_data_i [vbuf_geom_pkg::LANE_NUM],
  input  logic                  ren_i,
  input  logic                  write_done_i,
  input  logic                  read_done_i,
  input  logic                  not_empty_i,
  input  logic                  out_valid_i,
  input  vbuf_geom_pkg::addr_t  out_addr_i,
  input  vbuf_geom_pkg::word_t  out_data_i,
  input  vbuf_geom_pkg::be_t    out_strb_i,
  output int                    value_errs_o,
  output int                    flow_errs_o,
  output int                    pending_o
);

  vbuf_fmt_pkg::sew_e   m_sew;
  logic                 m_strided;
  vbuf_geom_pkg::addr_t m_stride;
  vbuf_geom_pkg::addr_t m_base;
  int                   m_elems;       // Elements in the current transfer
  int                   wr_beats;
  int                   rd_issued;
  int                   cycle;
  logic                 wr_done_exp;
  logic                 rd_done_exp;
  vbuf_geom_pkg::addr_t exp_addr;
  vbuf_geom_pkg::word_t exp_data;
  vbuf_geom_pkg::be_t   exp_strb;
  vbuf_fmt_pkg::elem_t  store [512];   // Written elements by index
  int                   due_q [$];     // Cycle in which each read must show up
  int                   idx_q [$];
  int                   value_errs = 0;
  int                   flow_errs  = 0;
  int                   pending    = 0;

  assign value_errs_o = value_errs;
  assign flow_errs_o  = flow_errs;
  assign pending_o    = pending;

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic int elem_count(input vbuf_fmt_pkg::sew_e sew, input logic [1:0] l2,
                                    input logic grow);
    int grp_bytes;
    grp_bytes = grow ? (vbuf_geom_pkg::VLENB << l2) : (vbuf_geom_pkg::VLENB >> l2);
    return grp_bytes / (1 << int'(sew));
  endfunction

  // Bus address, rotated data and strobe of element idx
  function automatic void expect_elem(input int idx, output vbuf_geom_pkg::addr_t addr,
                                      output vbuf_geom_pkg::word_t data,
                                      output vbuf_geom_pkg::be_t strb);
    int                   nbytes;
    vbuf_geom_pkg::addr_t step;
    vbuf_geom_pkg::addr_t elem_addr;
    vbuf_geom_pkg::word_t value;
    nbytes    = 1 << int'(m_sew);
    step      = m_strided ? m_stride : vbuf_geom_pkg::addr_t'(nbytes);
    elem_addr = m_base + vbuf_geom_pkg::addr_t'(idx) * step;
    value     = store[idx] & vbuf_geom_pkg::word_t'((64'd1 << (8 * nbytes)) - 1);
    addr      = {elem_addr[31:2], 2'b00};
    data      = value << (8 * elem_addr[1:0]);
    strb      = vbuf_geom_pkg::be_t'((1 << nbytes) - 1) << elem_addr[1:0];
  endfunction

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      value_errs++;
      $display("ERROR %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Compare on every rising edge, then advance the model
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (!rstn) begin
      m_elems   = 0;
      wr_beats  = 0;
      rd_issued = 0;
      cycle     = 0;
      due_q.delete();
      idx_q.delete();
    end else begin
      cycle++;
      wr_done_exp = (m_elems != 0) && (wr_beats == m_elems / vbuf_geom_pkg::LANE_NUM);
      rd_done_exp = (m_elems != 0) && (rd_issued == m_elems);
      check_flag("write_done_o", write_done_i, wr_done_exp);
      check_flag("read_done_o", read_done_i, rd_done_exp);
      check_flag("not_empty_o", not_empty_i, wr_beats != 0);
      if (due_q.size() != 0 && due_q[0] == cycle) begin
        expect_elem(idx_q[0], exp_addr, exp_data, exp_strb);
        if (out_valid_i !== 1'b1) begin
          flow_errs++;
          $display("Element %0d did not come out two cycles after its read, time %0t",
                   idx_q[0], $time);
        end else if (out_addr_i !== exp_addr || out_data_i !== exp_data ||
                     out_strb_i !== exp_strb) begin
          value_errs++;
          $display("ERROR %0t: element %0d gave %h %h %h, expected %h %h %h", $time, idx_q[0],
                   out_addr_i, out_data_i, out_strb_i, exp_addr, exp_data, exp_strb);
        end
        void'(due_q.pop_front());
        void'(idx_q.pop_front());
      end else if (out_valid_i !== 1'b0) begin
        flow_errs++;
        $display("Output pulse at time %0t with no accepted read two cycles earlier", $time);
      end
      if (cfg_update_i) begin
        if (due_q.size() != 0) begin
          flow_errs++;
          $display("Configuration update while %0d elements were still in flight", due_q.size());
        end
        due_q.delete();
        idx_q.delete();
        m_sew     = cfg_sew_i;
        m_strided = cfg_strided_i;
        m_stride  = cfg_stride_i;
        m_base    = cfg_base_i;
        m_elems   = elem_count(cfg_sew_i, cfg_l2_lmul_i, cfg_lmul_grow_i);
        wr_beats  = 0;
        rd_issued = 0;
      end else begin
        if (wen_i && !wr_done_exp) begin
          for (int l = 0; l < vbuf_geom_pkg::LANE_NUM; l++)
            store[wr_beats * vbuf_geom_pkg::LANE_NUM + l] = lane_data_i[l];
          wr_beats++;
        end
        if (ren_i && !rd_done_exp) begin
          due_q.push_back(cycle + 2);  // RAM read, then output register
          idx_q.push_back(rd_issued);
          rd_issued++;
        end
      end
    end
    pending = due_q.size();
  end

endmodule

/* tb_vbuf.sv */
// Testbench for the vector store buffer
// Unit-stride, narrow, strided, shrinking and full-buffer transfers with random lane data

`timescale 1ns/100ps

module tb_vbuf;

  localparam int TOTAL_ELEMS = 376;  // 16 + 64 + 128 + 32 + 8 + 128
  localparam int NUM_XFERS   = 6;
  // Up to two cycles per beat and per read, plus reset, settle time and margin
  localparam int CYCLE_LIMIT = 10 + 2 * (TOTAL_ELEMS + TOTAL_ELEMS / 4) + NUM_XFERS * 30 + 100;

  logic                 clk;
  logic                 rstn;
  logic                 cfg_update;
  vbuf_fmt_pkg::sew_e   cfg_sew;
  logic [1:0]           cfg_l2_lmul;
  logic                 cfg_lmul_grow;
  logic                 cfg_strided;
  vbuf_geom_pkg::addr_t cfg_stride;
  vbuf_geom_pkg::addr_t cfg_base;
  logic                 wen;
  vbuf_fmt_pkg::elem_t  lane_data [vbuf_geom_pkg::LANE_NUM];
  logic                 ren;
  logic                 write_done;
  logic                 read_done;
  logic                 not_empty;
  logic                 out_valid;
  vbuf_geom_pkg::addr_t out_addr;
  vbuf_geom_pkg::word_t out_data;
  vbuf_geom_pkg::be_t   out_strb;
  int                   value_errs;
  int                   flow_errs;
  int                   pending;
  int                   assert_errs;
  int                   cycle_cnt;
  integer               seed;

  vbuf_top i_dut (
    .clk, .rstn, .cfg_update_i(cfg_update), .cfg_sew_i(cfg_sew), .cfg_l2_lmul_i(cfg_l2_lmul),
    .cfg_lmul_grow_i(cfg_lmul_grow), .cfg_strided_i(cfg_strided), .cfg_stride_i(cfg_stride),
    .cfg_base_i(cfg_base), .wen_i(wen), .lane_data_i(lane_data), .ren_i(ren),
    .write_done_o(write_done), .read_done_o(read_done), .not_empty_o(not_empty),
    .out_valid_o(out_valid), .out_addr_o(out_addr), .out_data_o(out_data), .out_strb_o(out_strb)
  );

  vbuf_monitor i_mon (
    .clk, .rstn, .cfg_update_i(cfg_update), .cfg_sew_i(cfg_sew), .cfg_l2_lmul_i(cfg_l2_lmul),
    .cfg_lmul_grow_i(cfg_lmul_grow), .cfg_strided_i(cfg_strided), .cfg_stride_i(cfg_stride),
    .cfg_base_i(cfg_base), .wen_i(wen), .lane_data_i(lane_data), .ren_i(ren),
    .write_done_i(write_done), .read_done_i(read_done), .not_empty_i(not_empty),
    .out_valid_i(out_valid), .out_addr_i(out_addr), .out_data_i(out_data), .out_strb_i(out_strb),
    .value_errs_o(value_errs), .flow_errs_o(flow_errs), .pending_o(pending)
  );

  bind vbuf_top vbuf_checker i_checker (
    .clk, .rstn, .ren_i, .write_done_i(write_done_o), .read_done_i(read_done_o),
    .out_valid_i(out_valid_o), .out_strb_i(out_strb_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus tasks called and returning on a falling edge
  //////////////////////////////////////////////////////////////////////

  task automatic new_lane_data();
    for (int l = 0; l < vbuf_geom_pkg::LANE_NUM; l++)
      lane_data[l] = $random(seed);
  endtask

  task automatic set_config(input vbuf_fmt_pkg::sew_e sew, input logic [1:0] l2,
                            input logic grow, input logic strided,
                            input vbuf_geom_pkg::addr_t stride, input vbuf_geom_pkg::addr_t base);
    cfg_sew       = sew;
    cfg_l2_lmul   = l2;
    cfg_lmul_grow = grow;
    cfg_strided   = strided;
    cfg_stride    = stride;
    cfg_base      = base;
    cfg_update    = 1'b1;
    @(negedge clk);
    cfg_update = 1'b0;
  endtask

  // Write beats until the DUT reports the buffer full
  task automatic fill_buffer();
    while (!write_done) begin
      wen = 1'b1;
      new_lane_data();
      @(negedge clk);
      wen = 1'b0;
      if (($random(seed) & 3) == 0)
        @(negedge clk);  // Occasional idle cycle
    end
  endtask

  task automatic drain_buffer();
    while (!read_done) begin
      ren = 1'b1;
      @(negedge clk);
      ren = 1'b0;
      if (($random(seed) & 3) == 0)
        @(negedge clk);
    end
  endtask

  // Strobes after done must not change the buffer or the output
  task automatic late_strobes(input int n, input logic rd);
    repeat (n) begin
      wen = 1'b1;
      ren = rd;
      new_lane_data();
      @(negedge clk);
    end
    wen = 1'b0;
    ren = 1'b0;
  endtask

  task automatic run_transfer(input vbuf_fmt_pkg::sew_e sew, input logic [1:0] l2,
                              input logic grow, input logic strided,
                              input vbuf_geom_pkg::addr_t stride, input vbuf_geom_pkg::addr_t base);
    set_config(sew, l2, grow, strided, stride, base);
    fill_buffer();
    late_strobes(2, 1'b0);  // Extra writes after the last beat
    drain_buffer();
    late_strobes(2, 1'b1);
    repeat (4) @(negedge clk);  // Let the output pipeline empty
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    seed          = 32'h5c42;
    rstn          = 1'b0;
    cfg_update    = 1'b0;
    cfg_sew       = vbuf_fmt_pkg::SEW8;
    cfg_l2_lmul   = 2'd0;
    cfg_lmul_grow = 1'b0;
    cfg_strided   = 1'b0;
    cfg_stride    = '0;
    cfg_base      = '0;
    wen           = 1'b0;
    ren           = 1'b0;
    for (int l = 0; l < vbuf_geom_pkg::LANE_NUM; l++)
      lane_data[l] = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
    @(negedge clk);
    run_transfer(vbuf_fmt_pkg::SEW32, 2'd0, 1'b1, 1'b0, 32'd0, 32'h1000_0000);
    run_transfer(vbuf_fmt_pkg::SEW16, 2'd1, 1'b1, 1'b0, 32'd0, 32'h0000_2002);
    run_transfer(vbuf_fmt_pkg::SEW8, 2'd1, 1'b1, 1'b0, 32'd0, 32'h0000_3001);
    run_transfer(vbuf_fmt_pkg::SEW16, 2'd0, 1'b1, 1'b1, 32'd12, 32'h0000_4006);
    run_transfer(vbuf_fmt_pkg::SEW32, 2'd1, 1'b0, 1'b0, 32'd0, 32'h0000_5000);  // LMUL 1/2
    run_transfer(vbuf_fmt_pkg::SEW32, 2'd3, 1'b1, 1'b0, 32'd0, 32'h0000_6000);  // LMUL 8 fills every word
    assert_errs = i_dut.i_checker.fail_cnt;
    $display("Errors: %0d wrong values, %0d missing or extra outputs, %0d assertions, %0d pending",
             value_errs, flow_errs, assert_errs, pending);
    if (value_errs + flow_errs + assert_errs + pending == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles, the transfers did not finish", cycle_cnt);
    $display("sim failed");
    $finish;
  end

endmodule

/* compile.f */
vbuf_geom_pkg.sv
vbuf_fmt_pkg.sv
vbuf_config.sv
vbuf_lane_pack.sv
vbuf_lane_ram.sv
vbuf_addr_gen.sv
vbuf_drain.sv
vbuf_top.sv
vbuf_checker.sv
vbuf_monitor.sv
tb_vbuf.sv

/* Bender.yml */
package:
  name: vbuf

sources:
  # The format package uses the geometry package
  - vbuf_geom_pkg.sv
  - vbuf_fmt_pkg.sv
  - vbuf_config.sv
  - vbuf_lane_pack.sv
  - vbuf_lane_ram.sv
  - vbuf_addr_gen.sv
  - vbuf_drain.sv
  - vbuf_top.sv
  - target: simulation
    files:
      - vbuf_checker.sv
      - vbuf_monitor.sv
      - tb_vbuf.sv
